// ==== alu_system_pkg.sv ====
`default_nettype none

package alu_system_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////
    localparam int DATA_W    = 8;
    localparam int IR_W      = 16;
    localparam int MEM_DEPTH = 256;
    localparam int MAX_REGS  = 4;   // Width of a bank's enable mask

    localparam string MEM_INIT_FILE = "ram_init.mem";

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [IR_W-1:0]   ir_t;

    // Register function select
    typedef enum logic [1:0] {
        FUN_DEC   = 2'd0,
        FUN_INC   = 2'd1,
        FUN_LOAD  = 2'd2,
        FUN_CLEAR = 2'd3
    } reg_fun_e;

    typedef enum logic [3:0] {
        OP_PASS_A = 4'd0,
        OP_PASS_B = 4'd1,
        OP_NOT_A  = 4'd2,
        OP_NOT_B  = 4'd3,
        OP_ADD    = 4'd4,
        OP_ADC    = 4'd5,   // Adds stored carry
        OP_SUB    = 4'd6,
        OP_AND    = 4'd7,
        OP_OR     = 4'd8,
        OP_XOR    = 4'd9,
        OP_LSL    = 4'd10,
        OP_LSR    = 4'd11,
        OP_ASL    = 4'd12,
        OP_ASR    = 4'd13,
        OP_ROL    = 4'd14,  // Through carry
        OP_ROR    = 4'd15
    } alu_op_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic o;
    } flags_t;

    //////////////////////////////////////////////////
    // Control word
    //////////////////////////////////////////////////
    typedef struct packed {
        reg_fun_e            fun;
        logic [MAX_REGS-1:0] load_n;    // Active low, bit i is register i
        logic [1:0]          sel_a;
        logic [1:0]          sel_b;
    } bank_ctrl_t;

    typedef struct packed {
        bank_ctrl_t rf;
        bank_ctrl_t arf;
        logic [1:0] mux_a_sel;
        logic [1:0] mux_b_sel;
        logic       mux_c_sel;
        alu_op_e    alu_op;
        logic       flag_we;
        reg_fun_e   ir_fun;
        logic       ir_low;
        logic       ir_en;
        logic       mem_wr;
        logic       mem_cs_n;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== reg_bank.sv ====
`default_nettype none

module reg_bank #(
    parameter int NUM_REGS = 4
) (
    input  wire                       clk,
    input  wire                       reset,
    input  alu_system_pkg::bank_ctrl_t i_ctrl,
    input  alu_system_pkg::data_t      i_data,
    output alu_system_pkg::data_t      o_a,
    output alu_system_pkg::data_t      o_b
);
    import alu_system_pkg::*;

    // Low select codes fold onto register 0
    localparam int unsigned FOLD = MAX_REGS - NUM_REGS;
    localparam logic [MAX_REGS-1:0] UNUSED_MASK = {MAX_REGS{1'b1}} << NUM_REGS;

    data_t regs [NUM_REGS];

    function automatic int unsigned fold_sel(input logic [1:0] sel);
        if (sel < FOLD)
        begin
            return 0;
        end
        return sel - FOLD;
    endfunction

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                if (!i_ctrl.load_n[i])
                begin
                    case (i_ctrl.fun)
                        FUN_DEC:   regs[i] <= regs[i] - data_t'(1);   // Wraps 0 -> 255
                        FUN_INC:   regs[i] <= regs[i] + data_t'(1);
                        FUN_LOAD:  regs[i] <= i_data;
                        FUN_CLEAR: regs[i] <= '0;
                        default:   regs[i] <= regs[i];
                    endcase
                end
            end
        end
    end

    assign o_a = regs[fold_sel(i_ctrl.sel_a)];
    assign o_b = regs[fold_sel(i_ctrl.sel_b)];

    // Mask bits above the bank size stay inactive
    a_unused_mask: assert property (@(posedge clk) disable iff (reset)
        (i_ctrl.load_n & UNUSED_MASK) == UNUSED_MASK);

endmodule

`default_nettype wire

// ==== instr_reg.sv ====
`default_nettype none

module instr_reg (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     i_en,
    input  alu_system_pkg::reg_fun_e i_fun,
    input  wire                     i_low,
    input  alu_system_pkg::data_t    i_data,
    output alu_system_pkg::ir_t      o_ir
);
    import alu_system_pkg::*;

    ir_t ir_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ir_q <= '0;
        end
        else if (i_en)
        begin
            case (i_fun)
                FUN_DEC:   ir_q <= ir_q - ir_t'(1);
                FUN_INC:   ir_q <= ir_q + ir_t'(1);
                FUN_LOAD:
                begin
                    if (i_low)
                        ir_q[DATA_W-1:0] <= i_data;    // Other byte kept
                    else
                        ir_q[IR_W-1:DATA_W] <= i_data;
                end
                FUN_CLEAR: ir_q <= '0;
                default:   ir_q <= ir_q;
            endcase
        end
    end

    assign o_ir = ir_q;

endmodule

`default_nettype wire

// ==== bus_mux.sv ====
`default_nettype none

module bus_mux (
    input  wire [1:0]            i_mux_a_sel,
    input  wire [1:0]            i_mux_b_sel,
    input  wire                  i_mux_c_sel,
    input  alu_system_pkg::data_t i_alu,
    input  alu_system_pkg::data_t i_arf_c,
    input  alu_system_pkg::data_t i_rf_a,
    input  alu_system_pkg::data_t i_mem,
    input  alu_system_pkg::ir_t   i_ir,
    output alu_system_pkg::data_t o_rf_data,
    output alu_system_pkg::data_t o_arf_data,
    output alu_system_pkg::data_t o_alu_a
);
    import alu_system_pkg::*;

    data_t ir_low;

    assign ir_low = i_ir[DATA_W-1:0];

    always_comb
    begin
        // Register file load data
        case (i_mux_a_sel)
            2'd0:    o_rf_data = i_alu;
            2'd1:    o_rf_data = i_arf_c;
            2'd2:    o_rf_data = i_mem;
            default: o_rf_data = ir_low;
        endcase

        case (i_mux_b_sel)
            2'd0,
            2'd1:    o_arf_data = i_alu;
            2'd2:    o_arf_data = i_mem;
            default: o_arf_data = ir_low;
        endcase

        o_alu_a = i_mux_c_sel ? i_rf_a : i_arf_c;   // Operand A
    end

    // Routing selects are always driven by the control word
    always_comb
    begin
        a_sel_known: assert final (!$isunknown({i_mux_a_sel, i_mux_b_sel, i_mux_c_sel}));
    end

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`default_nettype none

module alu_unit (
    input  wire                     clk,
    input  wire                     reset,
    input  alu_system_pkg::alu_op_e  i_op,
    input  wire                     i_flag_we,
    input  alu_system_pkg::data_t    i_a,
    input  alu_system_pkg::data_t    i_b,
    output alu_system_pkg::data_t    o_result,
    output alu_system_pkg::flags_t   o_flags
);
    import alu_system_pkg::*;

    localparam int MSB = DATA_W - 1;

    flags_t        flags_q;
    flags_t        flags_nxt;
    data_t         result;
    data_t         b_op;
    logic          cin;
    logic [DATA_W:0] sum;

    //////////////////////////////////////////////////
    // Shared adder, SUB is A + ~B + 1
    //////////////////////////////////////////////////
    always_comb
    begin
        b_op = (i_op == OP_SUB) ? ~i_b : i_b;
        cin  = (i_op == OP_SUB) | ((i_op == OP_ADC) & flags_q.c);
        sum  = {1'b0, i_a} + {1'b0, b_op} + {{DATA_W{1'b0}}, cin};
    end

    always_comb
    begin
        flags_nxt = flags_q;    // c and o held unless set below
        case (i_op)
            OP_PASS_A: result = i_a;
            OP_PASS_B: result = i_b;
            OP_NOT_A:  result = ~i_a;
            OP_NOT_B:  result = ~i_b;
            OP_ADD,
            OP_ADC:
            begin
                result      = sum[MSB:0];
                flags_nxt.c = sum[DATA_W];
                flags_nxt.o = (i_a[MSB] == i_b[MSB]) && (result[MSB] != i_a[MSB]);
            end
            OP_SUB:
            begin
                result      = sum[MSB:0];
                flags_nxt.c = sum[DATA_W];
                flags_nxt.o = (i_a[MSB] != i_b[MSB]) && (result[MSB] != i_a[MSB]);
            end
            OP_AND:    result = i_a & i_b;
            OP_OR:     result = i_a | i_b;
            OP_XOR:    result = i_a ^ i_b;
            OP_LSL:
            begin
                result      = {i_a[MSB-1:0], 1'b0};
                flags_nxt.c = i_a[MSB];
            end
            OP_LSR:
            begin
                result      = {1'b0, i_a[MSB:1]};
                flags_nxt.c = i_a[0];
            end
            OP_ASL:
            begin
                result      = {i_a[MSB-1:0], 1'b0};
                flags_nxt.c = i_a[MSB];
                flags_nxt.o = i_a[MSB] ^ i_a[MSB-1];   // Sign bit changes
            end
            OP_ASR:
            begin
                result      = {i_a[MSB], i_a[MSB:1]};
                flags_nxt.c = i_a[0];
            end
            OP_ROL:
            begin
                result      = {i_a[MSB-1:0], flags_q.c};
                flags_nxt.c = i_a[MSB];
            end
            default:    // OP_ROR
            begin
                result      = {flags_q.c, i_a[MSB:1]};
                flags_nxt.c = i_a[0];
            end
        endcase
        flags_nxt.z = (result == '0);
        flags_nxt.n = result[MSB];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            flags_q <= '0;
        else if (i_flag_we)
            flags_q <= flags_nxt;
    end

    assign o_result = result;
    assign o_flags  = flags_q;

    a_flags_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(o_flags));

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`default_nettype none

module data_memory (
    input  wire                  clk,
    input  alu_system_pkg::data_t i_addr,
    input  alu_system_pkg::data_t i_wdata,
    input  wire                  i_wr,
    input  wire                  i_cs_n,
    output alu_system_pkg::data_t o_rdata
);
    import alu_system_pkg::*;

    data_t mem [MEM_DEPTH];

    initial
    begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    always_ff @(posedge clk)
    begin
        if (!i_cs_n && i_wr)
            mem[i_addr] <= i_wdata;
    end

    // Unselected or writing reads as zero
    assign o_rdata = (!i_cs_n && !i_wr) ? mem[i_addr] : '0;

    a_addr_known: assert property (@(posedge clk) !i_cs_n |-> !$isunknown(i_addr));

endmodule

`default_nettype wire

// ==== alu_system.sv ====
`default_nettype none

module alu_system (
    input  wire                    clk,
    input  wire                    reset,
    input  alu_system_pkg::ctrl_t   i_ctrl,
    output alu_system_pkg::data_t   o_alu_out,
    output alu_system_pkg::flags_t  o_flags,
    output alu_system_pkg::data_t   o_address,
    output alu_system_pkg::data_t   o_mem_data,
    output alu_system_pkg::ir_t     o_ir
);
    import alu_system_pkg::*;

    data_t rf_data;
    data_t arf_data;
    data_t rf_a;
    data_t rf_b;
    data_t arf_c;
    data_t alu_a;

    //////////////////////////////////////////////////
    // Register banks and IR
    //////////////////////////////////////////////////
    reg_bank #(.NUM_REGS(4)) rf0 (
        .clk(clk), .reset(reset), .i_ctrl(i_ctrl.rf), .i_data(rf_data),
        .o_a(rf_a), .o_b(rf_b)
    );

    // PC, AR, SP
    reg_bank #(.NUM_REGS(3)) arf0 (
        .clk(clk), .reset(reset), .i_ctrl(i_ctrl.arf), .i_data(arf_data),
        .o_a(arf_c), .o_b(o_address)
    );

    instr_reg ir0 (
        .clk(clk), .reset(reset), .i_en(i_ctrl.ir_en), .i_fun(i_ctrl.ir_fun),
        .i_low(i_ctrl.ir_low), .i_data(o_mem_data), .o_ir(o_ir)
    );

    bus_mux mux0 (
        .i_mux_a_sel(i_ctrl.mux_a_sel), .i_mux_b_sel(i_ctrl.mux_b_sel),
        .i_mux_c_sel(i_ctrl.mux_c_sel), .i_alu(o_alu_out), .i_arf_c(arf_c),
        .i_rf_a(rf_a), .i_mem(o_mem_data), .i_ir(o_ir),
        .o_rf_data(rf_data), .o_arf_data(arf_data), .o_alu_a(alu_a)
    );

    alu_unit alu0 (
        .clk(clk), .reset(reset), .i_op(i_ctrl.alu_op), .i_flag_we(i_ctrl.flag_we),
        .i_a(alu_a), .i_b(rf_b), .o_result(o_alu_out), .o_flags(o_flags)
    );

    data_memory mem0 (
        .clk(clk), .i_addr(o_address), .i_wdata(o_alu_out), .i_wr(i_ctrl.mem_wr),
        .i_cs_n(i_ctrl.mem_cs_n), .o_rdata(o_mem_data)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release lines up with the stimulus offset
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD / 10);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_alu_system.sv ====
`default_nettype none

module tb_alu_system;
    import alu_system_pkg::*;

    localparam int PERIOD  = 100;
    localparam int NUM_ALU = 24;
    localparam int NUM_WR  = 3;
    // set_ar costs at most 1 + address cycles
    localparam int TEST_CYCLES   = 10 + 4 * 19 + 20 + NUM_ALU * 36 + NUM_WR * 36 + 60 + 30;
    localparam int WATCHDOG_TIME = (TEST_CYCLES + 50) * PERIOD;

    logic   clk;
    logic   reset;
    ctrl_t  ctrl;
    data_t  alu_out;
    flags_t flags;
    data_t  address;
    data_t  mem_data;
    ir_t    ir;

    data_t       file_mem [16];
    data_t       exp_rf [4];
    data_t       exp_pc;
    data_t       exp_ar;
    data_t       exp_sp;
    ir_t         exp_ir;
    flags_t      exp_flags;
    flags_t      pend_flags;   // Loads on the edge that ends a flag_we word
    logic [31:0] rng;
    int          errors;
    int          err_mark;
    int          tests_ok;
    int          tests_bad;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) clk0 (.clk(clk), .reset(reset));

    alu_system dut0 (
        .clk(clk), .reset(reset), .i_ctrl(ctrl), .o_alu_out(alu_out), .o_flags(flags),
        .o_address(address), .o_mem_data(mem_data), .o_ir(ir)
    );

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    flags_match: assert property (@(negedge clk) disable iff (reset) flags == exp_flags)
    else
    begin
        $display("ERROR %0t o_flags expected %h actual %h", $time, exp_flags, flags);
        errors++;
    end

    // Deselected or writing memory reads as zero
    mem_idle_zero: assert property (@(negedge clk) disable iff (reset)
        (ctrl.mem_cs_n || ctrl.mem_wr) |-> mem_data == 8'h00)
    else
    begin
        $display("ERROR %0t o_mem_data expected 00 actual %h", $time, mem_data);
        errors++;
    end

    function automatic void check_val(input string name, input logic [15:0] exp,
                                      input logic [15:0] act);
        assert (act === exp)
        else
        begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Reference ALU with the next-flag rules
    function automatic void alu_model(input alu_op_e op, input data_t a, input data_t b,
                                      input flags_t f, output data_t r, output flags_t nf);
        int s;
        nf = f;
        s  = 0;
        case (op)
            OP_PASS_A: r = a;
            OP_PASS_B: r = b;
            OP_NOT_A:  r = ~a;
            OP_NOT_B:  r = ~b;
            OP_ADD,
            OP_ADC:
            begin
                s    = int'(a) + int'(b) + ((op == OP_ADC) ? int'(f.c) : 0);
                r    = data_t'(s);
                nf.c = (s > 255);
                nf.o = (a[7] == b[7]) && (r[7] != a[7]);
            end
            OP_SUB:
            begin
                s    = int'(a) + int'(data_t'(~b)) + 1;
                r    = data_t'(s);
                nf.c = (s > 255);
                nf.o = (a[7] != b[7]) && (r[7] != a[7]);
            end
            OP_AND:    r = a & b;
            OP_OR:     r = a | b;
            OP_XOR:    r = a ^ b;
            OP_LSL,
            OP_ASL:
            begin
                r    = data_t'(a << 1);
                nf.c = a[7];
                if (op == OP_ASL)
                    nf.o = (r[7] != a[7]);
            end
            OP_LSR:
            begin
                r    = a >> 1;
                nf.c = a[0];
            end
            OP_ASR:
            begin
                r    = data_t'($signed(a) >>> 1);
                nf.c = a[0];
            end
            OP_ROL:
            begin
                r    = {a[6:0], f.c};
                nf.c = a[7];
            end
            default:
            begin
                r    = {f.c, a[7:1]};
                nf.c = a[0];
            end
        endcase
        nf.z = (r == 8'h00);
        nf.n = r[7];
    endfunction

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    function automatic ctrl_t idle_word();
        ctrl_t c;
        c            = '0;
        c.rf.fun     = FUN_LOAD;
        c.rf.load_n  = 4'hf;
        c.arf.fun    = FUN_LOAD;
        c.arf.load_n = 4'hf;
        c.alu_op     = OP_PASS_A;
        c.ir_fun     = FUN_LOAD;
        c.mem_cs_n   = 1'b1;
        return c;
    endfunction

    // Returns mid-cycle, with combinational outputs settled
    task automatic apply_word(input ctrl_t c);
        @(posedge clk);
        if (ctrl.flag_we)
            exp_flags = pend_flags;
        #(PERIOD / 10);
        ctrl = c;
        #(PERIOD * 3 / 10);
    endtask

    task automatic set_ar(input int addr);
        ctrl_t c;
        c            = idle_word();
        c.arf.fun    = FUN_CLEAR;
        c.arf.load_n = 4'b1101;
        apply_word(c);
        c.arf.fun = FUN_INC;
        repeat (addr) apply_word(c);
        exp_ar = data_t'(addr);
    endtask

    task automatic load_rf(input int idx, input int addr);
        ctrl_t c;
        set_ar(addr);
        c           = idle_word();
        c.arf.sel_b = 2'd2;
        c.mem_cs_n  = 1'b0;
        c.mux_a_sel = 2'd2;         // Memory data
        c.rf.load_n = ~(4'b0001 << idx);
        apply_word(c);
        check_val("o_mem_data", file_mem[addr], mem_data);
        exp_rf[idx] = file_mem[addr];
    endtask

    task automatic check_all_rf();
        ctrl_t c;
        for (int i = 0; i < 4; i++)
        begin
            c          = idle_word();
            c.rf.sel_b = 2'(i);
            c.alu_op   = OP_PASS_B;
            apply_word(c);
            check_val("o_alu_out", exp_rf[i], alu_out);
        end
    endtask

    task automatic rf_op(input reg_fun_e fun, input logic [3:0] mask);
        ctrl_t c;
        c           = idle_word();
        c.rf.fun    = fun;
        c.rf.load_n = mask;
        apply_word(c);
        for (int i = 0; i < 4; i++)
        begin
            if (!mask[i])
            begin
                case (fun)
                    FUN_INC: exp_rf[i] = exp_rf[i] + 8'd1;
                    FUN_DEC: exp_rf[i] = exp_rf[i] - 8'd1;
                    default: exp_rf[i] = 8'h00;
                endcase
            end
        end
    endtask

    task automatic ir_step(input reg_fun_e fun, input logic low);
        ctrl_t c;
        c           = idle_word();
        c.ir_en     = 1'b1;
        c.ir_fun    = fun;
        c.ir_low    = low;
        c.mem_cs_n  = 1'b0;
        c.arf.sel_b = 2'd2;
        apply_word(c);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark)
        begin
            tests_ok++;
            $display("[%0t] %s: ok", $time, name);
        end
        else
        begin
            tests_bad++;
            $display("[%0t] %s: %0d errors", $time, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    initial
    begin
        ctrl_t   c;
        data_t   r;
        int      x;
        int      y;
        int      a;
        alu_op_e op;
        ctrl       = idle_word();
        rng        = 32'h907801d5;
        errors     = 0;
        err_mark   = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        exp_flags  = '0;
        pend_flags = '0;
        exp_pc     = 8'h00;
        exp_ar     = 8'h00;
        exp_sp     = 8'h00;
        exp_ir     = 16'h0000;
        $readmemh("ram_init.mem", file_mem);
        @(negedge reset);

        c          = idle_word();
        c.mem_cs_n = 1'b0;
        apply_word(c);
        check_val("o_ir", 16'h0000, ir);
        check_val("o_flags", 16'h0000, flags);
        check_val("o_address", 16'h0000, address);
        check_val("o_mem_data", file_mem[0], mem_data);
        end_test("reset values");

        for (int i = 0; i < 4; i++)
            load_rf(i, i + 4);
        check_all_rf();
        rf_op(FUN_INC, 4'b0000);
        check_all_rf();
        rf_op(FUN_CLEAR, 4'b1101);
        rf_op(FUN_DEC, 4'b1101);    // R1 wraps to ff
        check_all_rf();
        rf_op(FUN_DEC, 4'b0000);
        check_all_rf();
        end_test("register file");

        for (int k = 0; k < NUM_ALU; k++)
        begin
            rng = xorshift32(rng);
            x   = int'(rng[3:0]);
            y   = int'(rng[7:4]);
            op  = (k < 16) ? alu_op_e'(4'(k)) : alu_op_e'(rng[11:8]);
            load_rf(0, x);
            load_rf(1, y);
            c           = idle_word();
            c.mux_c_sel = 1'b1;
            c.rf.sel_b  = 2'd1;
            c.alu_op    = op;
            c.flag_we   = 1'b1;
            alu_model(op, exp_rf[0], exp_rf[1], exp_flags, r, pend_flags);
            apply_word(c);
            check_val("o_alu_out", r, alu_out);
        end
        end_test("alu operations");

        for (int w = 0; w < NUM_WR; w++)
        begin
            rng = xorshift32(rng);
            a   = 16 + int'(rng[3:0]);
            set_ar(a);
            c           = idle_word();
            c.arf.sel_b = 2'd2;
            c.rf.sel_b  = 2'(w);
            c.alu_op    = OP_PASS_B;
            c.mem_cs_n  = 1'b0;
            c.mem_wr    = 1'b1;
            apply_word(c);
            check_val("o_alu_out", exp_rf[w], alu_out);
            c.mem_wr = 1'b0;
            apply_word(c);
            check_val("o_mem_data", exp_rf[w], mem_data);
        end
        end_test("memory write");

        set_ar(1);
        ir_step(FUN_LOAD, 1'b0);
        set_ar(9);
        ir_step(FUN_LOAD, 1'b1);
        exp_ir = {file_mem[1], file_mem[9]};
        apply_word(idle_word());
        check_val("o_ir", exp_ir, ir);
        ir_step(FUN_CLEAR, 1'b0);
        set_ar(7);
        ir_step(FUN_LOAD, 1'b1);
        exp_ir = {8'h00, file_mem[7]};
        apply_word(idle_word());
        check_val("o_ir", exp_ir, ir);
        ir_step(FUN_INC, 1'b0);     // Carry into the high byte
        exp_ir = exp_ir + 16'd1;
        apply_word(idle_word());
        check_val("o_ir", exp_ir, ir);
        ir_step(FUN_DEC, 1'b0);
        exp_ir = exp_ir - 16'd1;
        apply_word(idle_word());
        check_val("o_ir", exp_ir, ir);
        end_test("instruction register");

        c            = idle_word();
        c.arf.fun    = FUN_INC;
        c.arf.load_n = 4'b1110;
        for (int k = 0; k < 3; k++)
        begin
            apply_word(c);
            check_val("o_address", exp_pc, address);
            exp_pc = exp_pc + 8'd1;
        end
        set_ar(5);
        c            = idle_word();
        c.arf.sel_b  = 2'd2;
        c.mem_cs_n   = 1'b0;
        c.mux_b_sel  = 2'd2;
        c.arf.load_n = 4'b1011;     // SP from memory
        apply_word(c);
        exp_sp = file_mem[5];
        for (int s = 0; s < 4; s++)
        begin
            c           = idle_word();
            c.arf.sel_a = 2'(s);
            c.arf.sel_b = 2'(s);
            apply_word(c);
            r = (s < 2) ? exp_pc : (s == 2) ? exp_ar : exp_sp;
            check_val("o_address", r, address);
            check_val("o_alu_out", r, alu_out);
        end
        end_test("address file");

        $display("Done: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Watchdog: tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ram_init.mem ====
// One hex byte per line, memory addresses 0 to 15 in order
3c
a5
00
7f
80
0c
01
ff
5a
c3
12
9e
64
e7
40
2b

// ==== list.f ====
alu_system_pkg.sv
reg_bank.sv
instr_reg.sv
bus_mux.sv
alu_unit.sv
data_memory.sv
alu_system.sv
tb_clock_gen.sv
tb_alu_system.sv

// ==== Bender.yml ====
package:
  name: alu_system

sources:
  - alu_system_pkg.sv
  - reg_bank.sv
  - instr_reg.sv
  - bus_mux.sv
  - alu_unit.sv
  - data_memory.sv
  - alu_system.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_alu_system.sv
